/* hw/data_mem_defs.svh */
`ifndef DATA_MEM_DEFS_SVH
`define DATA_MEM_DEFS_SVH

// words held by each byte lane, 2 KiB in total
`define DM_WORDS 512

// word index width inside one lane
`define DM_IDX_W 9

// display register, active low segments
`define DM_DISP_ADDR 32'h0000_07F8

// control register, bit 0 enables truncation
`define DM_CTRL_ADDR 32'h0000_07FC

`endif

/* hw/data_mem_pkg.sv */
`include "data_mem_defs.svh"

package data_mem_pkg;

    // data word and byte address
    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;

    // word index into one byte lane
    typedef logic [`DM_IDX_W-1:0] lane_idx_t;

    // one write enable per lane
    typedef logic [3:0] byte_en_t;

    // byte offset within a word
    typedef logic [1:0] align_t;

    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } mem_size_e;

endpackage

/* hw/mem_lane_if.sv */
`timescale 1ns/10ps

interface mem_lane_if;

    // one enable bit per lane
    data_mem_pkg::byte_en_t  lane_we;

    // per lane word index, write byte and registered read byte
    data_mem_pkg::lane_idx_t lane_idx [4];
    logic [7:0]              lane_wdata [4];
    logic [7:0]              lane_rdata [4];

    modport steer (
        output lane_we,
        output lane_idx,
        output lane_wdata
    );

    modport bank (
        input  lane_we,
        input  lane_idx,
        input  lane_wdata,
        output lane_rdata
    );

    modport gather (
        input  lane_rdata
    );

endinterface

/* hw/lane_ram.sv */
`timescale 1ns/10ps
`include "data_mem_defs.svh"

module lane_ram #(
    parameter int unsigned lane_num = 0
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       en,
    mem_lane_if.bank   lane
);

    logic [7:0]              mem [`DM_WORDS];
    logic [7:0]              rd_q;
    data_mem_pkg::lane_idx_t idx;

    assign idx = lane.lane_idx[lane_num];

    // write enable already carries en and wr_en
    always_ff @(posedge clk) begin
        if (lane.lane_we[lane_num]) begin
            mem[idx] <= lane.lane_wdata[lane_num];
        end
    end

    // read byte holds through a stall
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_q <= '0;
        end else if (en) begin
            rd_q <= mem[idx];
        end
    end

    assign lane.lane_rdata[lane_num] = rd_q;

endmodule

/* hw/store_steer.sv */
`timescale 1ns/10ps
`include "data_mem_defs.svh"

module store_steer (
    input  data_mem_pkg::addr_t     addr,
    input  logic                    wr_en,
    input  data_mem_pkg::mem_size_e req_size,
    input  data_mem_pkg::word_t     wr_data,
    input  logic                    en,
    mem_lane_if.steer               lanes
);

    data_mem_pkg::lane_idx_t idx_base;
    data_mem_pkg::lane_idx_t idx_next;
    data_mem_pkg::align_t    align;
    data_mem_pkg::byte_en_t  be_base;
    logic                    wr_go;

    assign idx_base = addr[`DM_IDX_W+1:2];
    assign align    = addr[1:0];

    // index width matches the lane depth, so +1 wraps to word 0
    assign idx_next = idx_base + 1'b1;

    assign wr_go = wr_en & en;

    always_comb begin
        case (req_size)
            data_mem_pkg::size_byte: be_base = 4'b0001;
            data_mem_pkg::size_half: be_base = 4'b0011;
            data_mem_pkg::size_word: be_base = 4'b1111;
            default:                 be_base = 4'b0000;
        endcase
    end

    // lane i carries the request byte at offset (i - align) mod 4
    always_comb begin
        logic [1:0] src;
        src = '0;
        for (int i = 0; i < 4; i++) begin
            src                 = 2'(i) - align;
            lanes.lane_wdata[i] = wr_data[8*src +: 8];
            lanes.lane_we[i]    = be_base[src] & wr_go;
            // lanes below the alignment point spill into the next word
            if (2'(i) < align) begin
                lanes.lane_idx[i] = idx_next;
            end else begin
                lanes.lane_idx[i] = idx_base;
            end
        end
    end

endmodule

/* hw/load_align.sv */
`timescale 1ns/10ps

module load_align (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    en,
    input  data_mem_pkg::addr_t     addr,
    input  data_mem_pkg::mem_size_e rsp_size,
    input  logic                    rsp_sext,
    input  logic                    trunc_en,
    mem_lane_if.gather              lanes,
    output data_mem_pkg::word_t     rd_data
);

    data_mem_pkg::align_t align_q;
    data_mem_pkg::word_t  rot;
    logic                 ext_bit;

    // alignment of the request whose bytes sit in the lane registers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            align_q <= '0;
        end else if (en) begin
            align_q <= addr[1:0];
        end
    end

    // byte k of the access lives in lane (k + align) mod 4
    always_comb begin
        for (int k = 0; k < 4; k++) begin
            rot[8*k +: 8] = lanes.lane_rdata[2'(k) + align_q];
        end
    end

    always_comb begin
        ext_bit = 1'b0;
        rd_data = rot;
        if (trunc_en) begin
            case (rsp_size)
                data_mem_pkg::size_byte: begin
                    ext_bit = rsp_sext & rot[7];
                    rd_data = {{24{ext_bit}}, rot[7:0]};
                end
                data_mem_pkg::size_half: begin
                    ext_bit = rsp_sext & rot[15];
                    rd_data = {{16{ext_bit}}, rot[15:0]};
                end
                default: begin
                    rd_data = rot;
                end
            endcase
        end
    end

endmodule

/* hw/mem_ctrl_regs.sv */
`timescale 1ns/10ps
`include "data_mem_defs.svh"

module mem_ctrl_regs (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                en,
    input  data_mem_pkg::addr_t addr,
    input  logic                wr_en,
    input  data_mem_pkg::word_t wr_data,
    output logic [15:0]         display_out,
    output logic                trunc_en
);

    logic wr_go;

    assign wr_go = wr_en & en;

    // segments are active low, all dark out of reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            display_out <= 16'hFFFF;
        end else if (wr_go && addr == `DM_DISP_ADDR) begin
            display_out <= ~wr_data[15:0];
        end
    end

    // truncation on by default
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            trunc_en <= 1'b1;
        end else if (wr_go && addr == `DM_CTRL_ADDR) begin
            trunc_en <= wr_data[0];
        end
    end

endmodule

/* hw/data_mem_top.sv */
`timescale 1ns/10ps

module data_mem_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    en,
    input  data_mem_pkg::addr_t     addr,
    input  logic                    wr_en,
    input  data_mem_pkg::mem_size_e req_size,
    input  data_mem_pkg::word_t     wr_data,
    input  data_mem_pkg::mem_size_e rsp_size,
    input  logic                    rsp_sext,
    output data_mem_pkg::word_t     rd_data,
    output logic [15:0]             display_out
);

    logic trunc_en;

    mem_lane_if lanes ();

    store_steer u_steer (
        .addr     (addr),
        .wr_en    (wr_en),
        .req_size (req_size),
        .wr_data  (wr_data),
        .en       (en),
        .lanes    (lanes.steer)
    );

    // one byte lane per instance, lane 0 holds address bits 1:0 = 0
    lane_ram #(.lane_num(0)) u_lane0 (
        .clk   (clk),
        .rst_n (rst_n),
        .en    (en),
        .lane  (lanes.bank)
    );

    lane_ram #(.lane_num(1)) u_lane1 (
        .clk   (clk),
        .rst_n (rst_n),
        .en    (en),
        .lane  (lanes.bank)
    );

    lane_ram #(.lane_num(2)) u_lane2 (
        .clk   (clk),
        .rst_n (rst_n),
        .en    (en),
        .lane  (lanes.bank)
    );

    lane_ram #(.lane_num(3)) u_lane3 (
        .clk   (clk),
        .rst_n (rst_n),
        .en    (en),
        .lane  (lanes.bank)
    );

    load_align u_align (
        .clk      (clk),
        .rst_n    (rst_n),
        .en       (en),
        .addr     (addr),
        .rsp_size (rsp_size),
        .rsp_sext (rsp_sext),
        .trunc_en (trunc_en),
        .lanes    (lanes.gather),
        .rd_data  (rd_data)
    );

    mem_ctrl_regs u_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .en          (en),
        .addr        (addr),
        .wr_en       (wr_en),
        .wr_data     (wr_data),
        .display_out (display_out),
        .trunc_en    (trunc_en)
    );

endmodule

/* testbench/data_mem_asserts.sv */
`timescale 1ns/10ps
`include "data_mem_defs.svh"

module data_mem_asserts (
    input logic                clk,
    input logic                rst_n,
    input logic                en,
    input data_mem_pkg::addr_t addr,
    input logic                wr_en,
    input data_mem_pkg::word_t rd_data,
    input logic [15:0]         display_out,
    input logic [3:0]          lane_we
);

    logic disp_written;

    // failed assertions so far
    int   fail_count = 0;

    // set once the display register has taken a store
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            disp_written <= 1'b0;
        end else if (en && wr_en && addr == `DM_DISP_ADDR) begin
            disp_written <= 1'b1;
        end
    end

    display_dark: assert property (
        @(posedge clk) disable iff (!rst_n)
        !disp_written |-> display_out == 16'hFFFF
    ) else begin
        $error("display_out changed before any display store");
        fail_count++;
    end

    no_write_in_stall: assert property (
        @(posedge clk) disable iff (!rst_n)
        !en |-> lane_we == 4'b0000
    ) else begin
        $error("lane write enable high while stalled");
        fail_count++;
    end

    // response cycle follows a taken load
    load_data_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        (en && !wr_en) |=> !$isunknown(rd_data)
    ) else begin
        $error("rd_data unknown in response cycle");
        fail_count++;
    end

endmodule

bind data_mem_top data_mem_asserts u_asserts (
    .clk         (clk),
    .rst_n       (rst_n),
    .en          (en),
    .addr        (addr),
    .wr_en       (wr_en),
    .rd_data     (rd_data),
    .display_out (display_out),
    .lane_we     (lanes.lane_we)
);

/* testbench/data_mem_tb.sv */
`timescale 1ns/10ps
`include "data_mem_defs.svh"

module data_mem_tb;

    logic                    clk;
    logic                    rst_n;
    logic                    en;
    data_mem_pkg::addr_t     addr;
    logic                    wr_en;
    data_mem_pkg::mem_size_e req_size;
    data_mem_pkg::word_t     wr_data;
    data_mem_pkg::mem_size_e rsp_size;
    logic                    rsp_sext;
    data_mem_pkg::word_t     rd_data;
    logic [15:0]             display_out;

    // byte model of the RAM and the side registers
    logic [7:0]  model_mem [2048];
    logic [15:0] model_disp;
    logic        model_trunc;

    logic [31:0] lfsr_state = 32'h06dd_4f98;

    // request driven last cycle and taken at the next edge
    logic                    prev_en;
    logic                    prev_load;
    logic [31:0]             pend_exp;
    data_mem_pkg::mem_size_e pend_size;
    logic                    pend_sext;

    // expectations for the current cycle
    logic        checking;
    logic        resp_valid;
    logic [31:0] resp_exp;
    logic [15:0] exp_disp;
    int          n_checks;

    data_mem_top dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .en          (en),
        .addr        (addr),
        .wr_en       (wr_en),
        .req_size    (req_size),
        .wr_data     (wr_data),
        .rsp_size    (rsp_size),
        .rsp_sext    (rsp_sext),
        .rd_data     (rd_data),
        .display_out (display_out)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // galois form with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r          = {r[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return r;
    endfunction

    function automatic data_mem_pkg::mem_size_e rand_size();
        return data_mem_pkg::mem_size_e'(rand_bits(2) % 3);
    endfunction

    function automatic int size_bytes(input data_mem_pkg::mem_size_e sz);
        case (sz)
            data_mem_pkg::size_byte: return 1;
            data_mem_pkg::size_half: return 2;
            default:                 return 4;
        endcase
    endfunction

    function automatic logic [31:0] fill_word(input logic [10:0] a);
        return {a, 10'h2B7, a} ^ {21'h0, ~a};
    endfunction

    // expected load result from bytes gathered modulo 2 KiB
    function automatic logic [31:0] ref_load(input logic [10:0] a,
                                             input data_mem_pkg::mem_size_e sz,
                                             input logic sext, input logic trunc);
        logic [31:0] w;
        logic [10:0] b;
        for (int k = 0; k < 4; k++) begin
            b           = a + 11'(k);
            w[8*k +: 8] = model_mem[b];
        end
        if (!trunc) begin
            return w;
        end
        case (sz)
            data_mem_pkg::size_byte: return {{24{sext & w[7]}}, w[7:0]};
            data_mem_pkg::size_half: return {{16{sext & w[15]}}, w[15:0]};
            default:                 return w;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] act,
                               input logic [31:0] exp);
        if (act !== exp) begin
            $display("[FAIL] time %0t ns, %s: expected %h, got %h", $time, name, exp, act);
            $display("TEST FAILED");
            $fatal(1, "stopping after mismatch");
        end
    endtask

    task automatic fail_timeout(input string what);
        $display("timed out waiting for %s", what);
        $display("TEST FAILED");
        $fatal(1, "stopping after timeout");
    endtask

    task automatic issue_req(input logic en_v, input logic wr, input logic [10:0] a,
                             input data_mem_pkg::mem_size_e sz, input logic [31:0] d,
                             input logic sext);
        logic [10:0] b;
        @(posedge clk);
        #1;
        // last cycle's request was taken at this edge when en was high
        if (prev_en) begin
            resp_valid = prev_load;
            if (prev_load) begin
                resp_exp = pend_exp;
                rsp_size = pend_size;
                rsp_sext = pend_sext;
            end
        end
        exp_disp  = model_disp;
        en        = en_v;
        wr_en     = wr;
        addr      = {21'h0, a};
        req_size  = sz;
        wr_data   = d;
        prev_en   = en_v;
        prev_load = !wr;
        if (en_v && wr) begin
            for (int k = 0; k < size_bytes(sz); k++) begin
                b            = a + 11'(k);
                model_mem[b] = d[8*k +: 8];
            end
            if ({21'h0, a} == `DM_DISP_ADDR) begin
                model_disp = ~d[15:0];
            end
            if ({21'h0, a} == `DM_CTRL_ADDR) begin
                model_trunc = d[0];
            end
        end else if (en_v) begin
            pend_exp  = ref_load(a, sz, sext, model_trunc);
            pend_size = sz;
            pend_sext = sext;
        end
    endtask

    task automatic store_at(input logic [10:0] a, input data_mem_pkg::mem_size_e sz,
                            input logic [31:0] d);
        issue_req(1'b1, 1'b1, a, sz, d, 1'b0);
    endtask

    task automatic load_at(input logic [10:0] a, input data_mem_pkg::mem_size_e sz,
                           input logic sext);
        issue_req(1'b1, 1'b0, a, sz, 32'h0, sext);
    endtask

    task automatic idle_cycle();
        issue_req(1'b0, 1'b0, 11'h0, data_mem_pkg::size_word, 32'h0, 1'b0);
    endtask

    // compare at the falling edge where inputs have settled
    always @(negedge clk) begin
        if (dut_i.u_asserts.fail_count != 0) begin
            $display("a bound assertion on the DUT failed");
            $display("TEST FAILED");
            $fatal(1, "stopping after assertion failure");
        end
        if (rst_n && checking) begin
            check_value("display_out", {16'h0, display_out}, {16'h0, exp_disp});
            if (resp_valid) begin
                check_value("rd_data", rd_data, resp_exp);
                n_checks++;
            end
        end
    end

    initial begin
        logic [31:0]             r;
        logic [31:0]             d;
        logic [10:0]             a;
        logic                    en_v;
        logic                    wr;
        logic                    sx;
        data_mem_pkg::mem_size_e sz;
        int                      wait_cnt;
        rst_n       = 1'b0;
        en          = 1'b0;
        addr        = '0;
        wr_en       = 1'b0;
        req_size    = data_mem_pkg::size_word;
        wr_data     = '0;
        rsp_size    = data_mem_pkg::size_word;
        rsp_sext    = 1'b0;
        model_disp  = 16'hFFFF;
        model_trunc = 1'b1;
        exp_disp    = 16'hFFFF;
        prev_en     = 1'b0;
        prev_load   = 1'b0;
        pend_exp    = '0;
        pend_size   = data_mem_pkg::size_word;
        pend_sext   = 1'b0;
        resp_valid  = 1'b0;
        resp_exp    = '0;
        checking    = 1'b0;
        n_checks    = 0;
        repeat (16) @(posedge clk);
        #1;
        rst_n    = 1'b1;
        wait_cnt = 0;
        while (display_out !== 16'hFFFF && wait_cnt < 8) begin
            @(posedge clk);
            wait_cnt++;
        end
        if (display_out !== 16'hFFFF) begin
            fail_timeout("reset release");
        end
        checking = 1'b1;

        // every word gets a known value first
        for (int i = 0; i < `DM_WORDS; i++) begin
            store_at(11'(i * 4), data_mem_pkg::size_word, fill_word(11'(i * 4)));
        end
        store_at(11'(`DM_CTRL_ADDR), data_mem_pkg::size_word, 32'h1);

        repeat (40) begin
            r = rand_bits(9);
            a = {r[8:0], 2'b00};
            d = rand_bits(32);
            store_at(a, data_mem_pkg::size_word, d);
            load_at(a, data_mem_pkg::size_word, 1'b0);
        end

        for (int off = 1; off < 4; off++) begin
            repeat (8) begin
                r = rand_bits(9);
                a = {r[8:0], 2'(off)};
                d = rand_bits(32);
                store_at(a, data_mem_pkg::size_word, d);
                load_at(a, data_mem_pkg::size_word, 1'b0);
            end
        end
        // wraps from the top word into word 0
        store_at(11'h7FD, data_mem_pkg::size_word, 32'hC3A5_5A3C);
        load_at(11'h7FD, data_mem_pkg::size_word, 1'b0);
        load_at(11'h7FE, data_mem_pkg::size_word, 1'b0);
        load_at(11'h7FF, data_mem_pkg::size_word, 1'b0);
        load_at(11'h000, data_mem_pkg::size_word, 1'b0);

        // random word stores may have cleared truncation
        store_at(11'(`DM_CTRL_ADDR), data_mem_pkg::size_word, 32'h1);
        for (int al = 0; al < 4; al++) begin
            r = rand_bits(9);
            store_at({r[8:0], 2'b00}, data_mem_pkg::size_word, 32'h8081_7F80);
            for (int s = 0; s < 2; s++) begin
                for (int x = 0; x < 2; x++) begin
                    load_at({r[8:0], 2'(al)}, data_mem_pkg::mem_size_e'(s), 1'(x));
                end
            end
        end

        repeat (16) begin
            r  = rand_bits(11);
            a  = r[10:0];
            sz = rand_bits(1) ? data_mem_pkg::size_half : data_mem_pkg::size_byte;
            d  = rand_bits(32);
            store_at(a, sz, d);
            load_at({a[10:2], 2'b00}, data_mem_pkg::size_word, 1'b0);
            load_at({a[10:2], 2'b00} + 11'd4, data_mem_pkg::size_word, 1'b0);
        end

        store_at(11'(`DM_CTRL_ADDR), data_mem_pkg::size_word, 32'h0);
        load_at(11'h123, data_mem_pkg::size_byte, 1'b1);
        load_at(11'h246, data_mem_pkg::size_half, 1'b1);
        store_at(11'(`DM_CTRL_ADDR), data_mem_pkg::size_word, 32'h1);
        load_at(11'h123, data_mem_pkg::size_byte, 1'b1);
        load_at(11'h246, data_mem_pkg::size_half, 1'b0);
        store_at(11'(`DM_DISP_ADDR), data_mem_pkg::size_word, 32'h1234_A55A);
        idle_cycle();
        check_value("display_out", {16'h0, display_out}, 32'h0000_5AA5);

        // mixed traffic with stalls
        repeat (300) begin
            en_v = rand_bits(2) != 0;
            wr   = rand_bits(1);
            r    = rand_bits(11);
            sz   = rand_size();
            d    = rand_bits(32);
            sx   = rand_bits(1);
            issue_req(en_v, wr, r[10:0], sz, d, sx);
        end
        idle_cycle();
        idle_cycle();
        @(posedge clk);
        #1;

        if (n_checks == 0) begin
            $display("no load response was checked");
            $display("TEST FAILED");
            $fatal(1, "stopping without checks");
        end else if (dut_i.u_asserts.fail_count != 0) begin
            $display("a bound assertion on the DUT failed");
            $display("TEST FAILED");
            $fatal(1, "stopping after assertion failure");
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule

/* data_mem_top.f */
+incdir+hw
hw/data_mem_pkg.sv
hw/mem_lane_if.sv
hw/lane_ram.sv
hw/store_steer.sv
hw/load_align.sv
hw/mem_ctrl_regs.sv
hw/data_mem_top.sv
testbench/data_mem_asserts.sv
testbench/data_mem_tb.sv
